// ==== Makefile ====
TOP := tb_buffer_manager
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG) || ! grep -q '\*\* PASS \*\*' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== logic/bm_consts.svh ====
`ifndef BM_CONSTS_SVH
`define BM_CONSTS_SVH

// ----------------------------------------------------------------------
// layer shape fields
// ----------------------------------------------------------------------
`define BM_W_SIZE       6   // width / height
`define BM_W_CHANNEL    5   // channel count

// ----------------------------------------------------------------------
// feature map buffers
// ----------------------------------------------------------------------
// 256 words per buffer
`define BM_FM_AW        8
`define BM_FM_DW        32

// ----------------------------------------------------------------------
// filter banks
// ----------------------------------------------------------------------
// 64 kernels per bank
`define BM_FILTER_AW    6
// one 3x3 kernel, one byte per tap
`define BM_KERNEL_BYTES 9
// one bank per AXI byte lane
`define BM_FILTER_LANES 4

`endif

// ==== logic/bm_ctrl.sv ====
`timescale 1ns/100ps
`include "bm_consts.svh"

module bm_ctrl (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     q_load_ifm,
    input  logic                     q_load_filter,
    input  bm_pkg::fm_word_t         read_data,
    input  logic                     read_data_vld,
    input  logic                     switch_req,
    output logic                     switch_ack,
    input  logic [`BM_W_SIZE-1:0]    q_width,
    input  logic [`BM_W_SIZE-1:0]    q_height,
    input  logic [`BM_W_CHANNEL-1:0] q_channel_out,
    input  logic                     ofm_wr_en,
    input  bm_pkg::fm_addr_t         ofm_addr,
    output logic                     ofm_done,
    input  logic                     last_write,
    output logic                     filter_load_start,
    output logic                     filter_ready,
    fm_ctrl_if.ctrl                  fm
);

    logic                                  load_ifm_d;
    logic                                  load_filter_d;
    logic                                  ifm_start;
    logic                                  filter_start;
    bm_pkg::fm_role_t                      buf0_role;
    logic                                  axi_active;
    logic                                  axi_wr_en;
    bm_pkg::fm_addr_t                      axi_wr_addr;
    bm_pkg::fm_word_t                      axi_wr_data;
    logic [2*`BM_W_SIZE+`BM_W_CHANNEL-1:0] ofm_words;
    bm_pkg::fm_addr_t                      ofm_last_addr;

    assign ifm_start    = q_load_ifm & ~load_ifm_d;
    assign filter_start = q_load_filter & ~load_filter_d;

    // ------------------------------------------------------------------
    // load edges and filter flags
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            load_ifm_d        <= 1'b0;
            load_filter_d     <= 1'b0;
            filter_load_start <= 1'b0;
            filter_ready      <= 1'b0;
        end else begin
            load_ifm_d        <= q_load_ifm;
            load_filter_d     <= q_load_filter;
            filter_load_start <= filter_start;   // packer restarts one cycle later
            if (filter_start)
                filter_ready <= 1'b0;           // new load wins over a late last write
            else if (last_write)
                filter_ready <= 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // layer switch, four-phase req/ack
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            buf0_role  <= bm_pkg::FM_IFM;
            switch_ack <= 1'b0;
        end else if (switch_req && !switch_ack) begin
            buf0_role  <= (buf0_role == bm_pkg::FM_IFM) ? bm_pkg::FM_OFM : bm_pkg::FM_IFM;
            switch_ack <= 1'b1;
        end else if (!switch_req) begin
            switch_ack <= 1'b0;
        end
    end

    // ------------------------------------------------------------------
    // AXI append into buffer 0
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            axi_active  <= 1'b0;
            axi_wr_en   <= 1'b0;
            axi_wr_addr <= '0;
        end else begin
            axi_active <= q_load_ifm;
            axi_wr_en  <= q_load_ifm & read_data_vld;
            if (ifm_start)
                axi_wr_addr <= '0;
            else if (axi_wr_en)
                axi_wr_addr <= axi_wr_addr + 1'b1;   // step after each write
        end
    end

    always_ff @(posedge clk) begin
        axi_wr_data <= read_data;
    end

    assign fm.buf0_role   = buf0_role;
    assign fm.axi_active  = axi_active;
    assign fm.axi_wr_en   = axi_wr_en;
    assign fm.axi_wr_addr = axi_wr_addr;
    assign fm.axi_wr_data = axi_wr_data;

    // last OFM word of the layer, w * h * c_out - 1
    assign ofm_words     = q_width * q_height * q_channel_out;
    assign ofm_last_addr = bm_pkg::fm_addr_t'(ofm_words - 1'b1);
    assign ofm_done      = ofm_wr_en && (ofm_addr == ofm_last_addr);

endmodule

// ==== logic/bm_dpram.sv ====
`timescale 1ns/100ps

// simple dual port RAM, one write port and one registered read port
module bm_dpram #(
    parameter type payload_t = logic,
    parameter int  AW        = 4
) (
    input  logic          clk,
    // write port
    input  logic          wr_en,
    input  logic [AW-1:0] wr_addr,
    input  payload_t      wr_data,
    // read port
    input  logic          rd_en,
    input  logic [AW-1:0] rd_addr,
    output payload_t      rd_data
);

    payload_t mem [2**AW];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read during write to the same address returns the old word
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== logic/bm_if.sv ====
`timescale 1ns/100ps

// ----------------------------------------------------------------------
// control to feature map datapath
// ----------------------------------------------------------------------
interface fm_ctrl_if;

    bm_pkg::fm_role_t buf0_role;    // buffer 1 always holds the other role
    logic             axi_active;   // load in progress, AXI owns buffer 0
    logic             axi_wr_en;
    bm_pkg::fm_addr_t axi_wr_addr;
    bm_pkg::fm_word_t axi_wr_data;

    modport ctrl (
        output buf0_role,
        output axi_active,
        output axi_wr_en,
        output axi_wr_addr,
        output axi_wr_data
    );

    modport datapath (
        input  buf0_role,
        input  axi_active,
        input  axi_wr_en,
        input  axi_wr_addr,
        input  axi_wr_data
    );

endinterface

// ----------------------------------------------------------------------
// packer to filter banks, one shared address for all lanes
// ----------------------------------------------------------------------
interface filter_wr_if;

    logic                 wr_en;
    bm_pkg::filter_addr_t wr_addr;
    bm_pkg::filter_set_t  wr_data;

    modport packer (output wr_en, output wr_addr, output wr_data);
    modport bank   (input  wr_en, input  wr_addr, input  wr_data);

endinterface

// ==== logic/bm_pkg.sv ====
`include "bm_consts.svh"

package bm_pkg;

    // ------------------------------------------------------------------
    // feature map side
    // ------------------------------------------------------------------
    typedef logic [`BM_FM_DW-1:0] fm_word_t;
    typedef logic [`BM_FM_AW-1:0] fm_addr_t;

    // role of a feature buffer in the current layer
    typedef enum logic {
        FM_IFM = 1'b0,  // read side, tap port
        FM_OFM = 1'b1   // write side, post-processor
    } fm_role_t;

    // ------------------------------------------------------------------
    // filter side
    // ------------------------------------------------------------------
    // byte k of the kernel sits at bits 8k+7..8k
    typedef logic [8*`BM_KERNEL_BYTES-1:0] filter_word_t;
    typedef logic [`BM_FILTER_AW-1:0] filter_addr_t;

    // one kernel per bank, index = AXI byte lane
    typedef filter_word_t [`BM_FILTER_LANES-1:0] filter_set_t;

endpackage

// ==== logic/buffer_manager.sv ====
`timescale 1ns/100ps
`include "bm_consts.svh"

module buffer_manager (
    input  logic                     clk,
    input  logic                     rstn,
    // layer shape
    input  logic [`BM_W_SIZE-1:0]    q_width,
    input  logic [`BM_W_SIZE-1:0]    q_height,
    input  logic [`BM_W_CHANNEL-1:0] q_channel,
    input  logic [`BM_W_CHANNEL-1:0] q_channel_out,
    // load control and layer switch
    input  logic                     q_load_ifm,
    input  logic                     q_load_filter,
    input  logic                     switch_req,
    output logic                     switch_ack,
    // AXI read stream
    input  bm_pkg::fm_word_t         read_data,
    input  logic                     read_data_vld,
    // tap port, IFM side
    input  logic                     tap_read_en,
    input  bm_pkg::fm_addr_t         tap_read_addr,
    output bm_pkg::fm_word_t         tap_read_data,
    // post-processor, OFM side
    input  logic                     ofm_wr_en,
    input  bm_pkg::fm_addr_t         ofm_addr,
    input  bm_pkg::fm_word_t         ofm_data,
    output logic                     ofm_done,
    // filter read
    output logic                     filter_ready,
    input  logic                     fb_req,
    input  bm_pkg::filter_addr_t     fb_addr,
    output bm_pkg::filter_word_t     fb_data0,
    output bm_pkg::filter_word_t     fb_data1,
    output bm_pkg::filter_word_t     fb_data2,
    output bm_pkg::filter_word_t     fb_data3
);

    logic                 filter_load_start;
    logic                 last_write;
    bm_pkg::filter_word_t fb_rd_data [`BM_FILTER_LANES];

    fm_ctrl_if   u_fm_if ();
    filter_wr_if u_fw_if ();

    bm_ctrl u_ctrl (
        .clk               (clk),
        .rstn              (rstn),
        .q_load_ifm        (q_load_ifm),
        .q_load_filter     (q_load_filter),
        .read_data         (read_data),
        .read_data_vld     (read_data_vld),
        .switch_req        (switch_req),
        .switch_ack        (switch_ack),
        .q_width           (q_width),
        .q_height          (q_height),
        .q_channel_out     (q_channel_out),
        .ofm_wr_en         (ofm_wr_en),
        .ofm_addr          (ofm_addr),
        .ofm_done          (ofm_done),
        .last_write        (last_write),
        .filter_load_start (filter_load_start),
        .filter_ready      (filter_ready),
        .fm                (u_fm_if.ctrl)
    );

    fm_pingpong u_fm_pingpong (
        .clk           (clk),
        .fm            (u_fm_if.datapath),
        .ofm_wr_en     (ofm_wr_en),
        .ofm_addr      (ofm_addr),
        .ofm_data      (ofm_data),
        .tap_read_en   (tap_read_en),
        .tap_read_addr (tap_read_addr),
        .tap_read_data (tap_read_data)
    );

    filter_packer u_filter_packer (
        .clk               (clk),
        .rstn              (rstn),
        .q_load_filter     (q_load_filter),
        .q_channel         (q_channel),
        .read_data         (read_data),
        .read_data_vld     (read_data_vld),
        .filter_load_start (filter_load_start),
        .last_write        (last_write),
        .fw                (u_fw_if.packer)
    );

    // ------------------------------------------------------------------
    // filter banks, all lanes share write and read addresses
    // ------------------------------------------------------------------
    for (genvar j = 0; j < `BM_FILTER_LANES; j++) begin : g_filter_bank
        bm_dpram #(
            .payload_t (bm_pkg::filter_word_t),
            .AW        (`BM_FILTER_AW)
        ) u_filter_bank (
            .clk     (clk),
            .wr_en   (u_fw_if.wr_en),
            .wr_addr (u_fw_if.wr_addr),
            .wr_data (u_fw_if.wr_data[j]),
            .rd_en   (fb_req),
            .rd_addr (fb_addr),
            .rd_data (fb_rd_data[j])
        );
    end

    assign fb_data0 = fb_rd_data[0];
    assign fb_data1 = fb_rd_data[1];
    assign fb_data2 = fb_rd_data[2];
    assign fb_data3 = fb_rd_data[3];

endmodule

// ==== logic/filter_packer.sv ====
`timescale 1ns/100ps
`include "bm_consts.svh"

module filter_packer (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     q_load_filter,
    input  logic [`BM_W_CHANNEL-1:0] q_channel,
    input  bm_pkg::fm_word_t         read_data,
    input  logic                     read_data_vld,
    input  logic                     filter_load_start,
    output logic                     last_write,
    filter_wr_if.packer              fw
);

    logic [3:0]           kpos;        // byte position inside the kernel
    logic [3:0]           kpos_use;
    logic                 word_vld;
    logic                 kcommit;     // ninth byte taken this cycle
    logic                 kcommit_d;
    bm_pkg::filter_addr_t wr_addr;
    bm_pkg::filter_addr_t last_addr;
    bm_pkg::filter_set_t  kernel_acc;

    // ------------------------------------------------------------------
    // byte position
    // ------------------------------------------------------------------
    // the source sends the first word no earlier than the start pulse,
    // a word on the start pulse is byte 0
    assign word_vld  = q_load_filter & read_data_vld;
    assign kpos_use  = filter_load_start ? 4'd0 : kpos;
    assign kcommit   = word_vld && (kpos_use == 4'(`BM_KERNEL_BYTES - 1));

    // 4 kernels per input channel
    assign last_addr = bm_pkg::filter_addr_t'(`BM_FILTER_LANES * q_channel - 1);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            kpos      <= 4'd0;
            kcommit_d <= 1'b0;
            wr_addr   <= '0;
        end else begin
            kcommit_d <= kcommit;

            if (word_vld)
                kpos <= kcommit ? 4'd0 : kpos_use + 4'd1;
            else if (filter_load_start)
                kpos <= 4'd0;

            // wrapping kernel address, steps on each bank write
            if (filter_load_start)
                wr_addr <= '0;
            else if (kcommit_d)
                wr_addr <= (wr_addr == last_addr) ? '0 : wr_addr + 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // kernel accumulators, lane j of the word goes to bank j
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (word_vld) begin
            for (int j = 0; j < `BM_FILTER_LANES; j++) begin
                kernel_acc[j][8*kpos_use +: 8] <= read_data[8*j +: 8];
            end
        end
    end

    // ------------------------------------------------------------------
    // bank write, one cycle after the commit
    // ------------------------------------------------------------------
    // byte 0 of the next kernel lands at the same edge, the write sees the old set
    assign fw.wr_en   = kcommit_d;
    assign fw.wr_addr = wr_addr;
    assign fw.wr_data = kernel_acc;

    assign last_write = kcommit_d && (wr_addr == last_addr);

endmodule

// ==== logic/fm_pingpong.sv ====
`timescale 1ns/100ps
`include "bm_consts.svh"

module fm_pingpong (
    input  logic             clk,
    fm_ctrl_if.datapath      fm,
    // post-processor write side
    input  logic             ofm_wr_en,
    input  bm_pkg::fm_addr_t ofm_addr,
    input  bm_pkg::fm_word_t ofm_data,
    // tap read side
    input  logic             tap_read_en,
    input  bm_pkg::fm_addr_t tap_read_addr,
    output bm_pkg::fm_word_t tap_read_data
);

    logic             buf0_is_ifm;
    logic             buf0_wr_en;
    bm_pkg::fm_addr_t buf0_wr_addr;
    bm_pkg::fm_word_t buf0_wr_data;
    logic             buf1_wr_en;
    logic             buf0_rd_en;
    logic             buf1_rd_en;
    bm_pkg::fm_word_t buf0_rd_data;
    bm_pkg::fm_word_t buf1_rd_data;
    logic             rd_from_buf0;

    assign buf0_is_ifm = (fm.buf0_role == bm_pkg::FM_IFM);

    // ------------------------------------------------------------------
    // write routing
    // ------------------------------------------------------------------
    // AXI load owns buffer 0 whatever its role
    always_comb begin
        if (fm.axi_active) begin
            buf0_wr_en   = fm.axi_wr_en;
            buf0_wr_addr = fm.axi_wr_addr;
            buf0_wr_data = fm.axi_wr_data;
        end else begin
            buf0_wr_en   = ofm_wr_en & ~buf0_is_ifm;
            buf0_wr_addr = ofm_addr;
            buf0_wr_data = ofm_data;
        end
    end

    assign buf1_wr_en = ofm_wr_en & buf0_is_ifm;   // buffer 1 is OFM side

    // ------------------------------------------------------------------
    // tap read from the IFM side
    // ------------------------------------------------------------------
    assign buf0_rd_en = tap_read_en & buf0_is_ifm;
    assign buf1_rd_en = tap_read_en & ~buf0_is_ifm;

    // keep the select of the read, a switch may land before the data
    always_ff @(posedge clk) begin
        if (tap_read_en) begin
            rd_from_buf0 <= buf0_is_ifm;
        end
    end

    assign tap_read_data = rd_from_buf0 ? buf0_rd_data : buf1_rd_data;

    bm_dpram #(
        .payload_t (bm_pkg::fm_word_t),
        .AW        (`BM_FM_AW)
    ) u_fm_buf0 (
        .clk     (clk),
        .wr_en   (buf0_wr_en),
        .wr_addr (buf0_wr_addr),
        .wr_data (buf0_wr_data),
        .rd_en   (buf0_rd_en),
        .rd_addr (tap_read_addr),
        .rd_data (buf0_rd_data)
    );

    bm_dpram #(
        .payload_t (bm_pkg::fm_word_t),
        .AW        (`BM_FM_AW)
    ) u_fm_buf1 (
        .clk     (clk),
        .wr_en   (buf1_wr_en),
        .wr_addr (ofm_addr),
        .wr_data (ofm_data),
        .rd_en   (buf1_rd_en),
        .rd_addr (tap_read_addr),
        .rd_data (buf1_rd_data)
    );

endmodule

// ==== tb.f ====
+incdir+logic
logic/bm_pkg.sv
logic/bm_if.sv
logic/bm_dpram.sv
logic/bm_ctrl.sv
logic/fm_pingpong.sv
logic/filter_packer.sv
logic/buffer_manager.sv
verification/bm_properties.sv
verification/tb_buffer_manager.sv

// ==== verification/bm_properties.sv ====
`timescale 1ns/100ps

module bm_properties (
    input logic clk,
    input logic rstn,
    input logic switch_req,
    input logic switch_ack,
    input logic q_load_filter,
    input logic filter_ready
);

    int failures = 0;   // summed into the testbench summary

    // ----------------------------------------------------------------------
    // layer switch handshake
    // ----------------------------------------------------------------------
    // ack holds while req is still up
    ack_held: assert property (@(posedge clk) disable iff (!rstn)
        switch_ack && switch_req |=> switch_ack)
        else begin
            failures++;
            $error("switch_ack dropped while switch_req was still high");
        end

    // ack may only fall once req was seen low
    ack_fall_after_req: assert property (@(posedge clk) disable iff (!rstn)
        $fell(switch_ack) |-> !$past(switch_req))
        else begin
            failures++;
            $error("switch_ack fell before switch_req was released");
        end

    // ----------------------------------------------------------------------
    // filter ready flag
    // ----------------------------------------------------------------------
    ready_cleared: assert property (@(posedge clk) disable iff (!rstn)
        $rose(q_load_filter) |=> !filter_ready)
        else begin
            failures++;
            $error("filter_ready still high after a new filter load started");
        end

endmodule

bind buffer_manager bm_properties i_props (
    .clk           (clk),
    .rstn          (rstn),
    .switch_req    (switch_req),
    .switch_ack    (switch_ack),
    .q_load_filter (q_load_filter),
    .filter_ready  (filter_ready)
);

// ==== verification/tb_buffer_manager.sv ====
`timescale 1ns/100ps
`include "bm_consts.svh"

module tb_buffer_manager;

    localparam int CLK_PERIOD    = 4;
    localparam int IFM_WORDS     = 40;
    localparam int SHAPE_W       = 2;
    localparam int SHAPE_H       = 3;
    localparam int SHAPE_C_OUT   = 4;
    localparam int OFM_WORDS     = SHAPE_W * SHAPE_H * SHAPE_C_OUT;
    localparam int FILTER_CH     = 2;
    localparam int KERNELS       = `BM_FILTER_LANES * FILTER_CH;
    localparam int FILTER_WORDS  = `BM_KERNEL_BYTES * KERNELS;
    // one kernel and part of the next
    localparam int PARTIAL_WORDS = `BM_KERNEL_BYTES + 4;
    // rough upper bound on stimulus cycles, random gaps included
    localparam int STIM_CYCLES   = 8 * IFM_WORDS + 3 * OFM_WORDS + 4 * 16
                                   + 2 * (2 * FILTER_WORDS + 2 * KERNELS + 12)
                                   + 2 * PARTIAL_WORDS + 6;

    logic                     clk;
    logic                     rstn;
    logic [`BM_W_SIZE-1:0]    q_width;
    logic [`BM_W_SIZE-1:0]    q_height;
    logic [`BM_W_CHANNEL-1:0] q_channel;
    logic [`BM_W_CHANNEL-1:0] q_channel_out;
    logic                     q_load_ifm;
    logic                     q_load_filter;
    logic                     switch_req;
    logic                     switch_ack;
    bm_pkg::fm_word_t         read_data;
    logic                     read_data_vld;
    logic                     tap_read_en;
    bm_pkg::fm_addr_t         tap_read_addr;
    bm_pkg::fm_word_t         tap_read_data;
    logic                     ofm_wr_en;
    bm_pkg::fm_addr_t         ofm_addr;
    bm_pkg::fm_word_t         ofm_data;
    logic                     ofm_done;
    logic                     filter_ready;
    logic                     fb_req;
    bm_pkg::filter_addr_t     fb_addr;
    bm_pkg::filter_word_t     fb_data0;
    bm_pkg::filter_word_t     fb_data1;
    bm_pkg::filter_word_t     fb_data2;
    bm_pkg::filter_word_t     fb_data3;

    bm_pkg::fm_word_t ifm_words [$];     // in load order = buffer address
    bm_pkg::fm_word_t ofm_words [$];
    bm_pkg::fm_word_t filter_words [$];  // n-th valid word of the current filter load
    int               checks = 0;
    int               errors = 0;

    buffer_manager i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(20 * STIM_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display("** FAIL **");
        $finish;
    end

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    task automatic compare(input logic [71:0] got, input logic [71:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic read_tap(input bm_pkg::fm_addr_t addr, output bm_pkg::fm_word_t data);
        @(posedge clk);
        tap_read_en   <= 1'b1;
        tap_read_addr <= addr;
        @(posedge clk);
        tap_read_en <= 1'b0;
        @(negedge clk);                  // registered read has settled
        data = tap_read_data;
    endtask

    task automatic check_tap_data(input bm_pkg::fm_word_t exp_words [$], input string what);
        bm_pkg::fm_word_t got;
        foreach (exp_words[a]) begin
            read_tap(bm_pkg::fm_addr_t'(a), got);
            compare(got, exp_words[a], $sformatf("%s tap word %0d", what, a));
        end
    endtask

    // random gaps in the valid stream, no back-pressure
    task automatic send_word(output bit sent, output bm_pkg::fm_word_t w);
        @(posedge clk);
        w    = $urandom;
        sent = ($urandom_range(3) != 0);
        read_data     <= w;
        read_data_vld <= sent;
    endtask

    task automatic load_ifm_words(input int n);
        bm_pkg::fm_word_t w;
        bit               sent;
        @(posedge clk);
        q_load_ifm <= 1'b1;
        while (ifm_words.size() < n) begin
            send_word(sent, w);
            if (sent)
                ifm_words.push_back(w);
        end
        @(posedge clk);
        read_data_vld <= 1'b0;
        @(posedge clk);
        q_load_ifm <= 1'b0;              // last word is in buffer 0 by now
    endtask

    task automatic layer_switch(input int hold);
        int n;
        @(posedge clk);
        switch_req <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!switch_ack && n < 3);
        compare(switch_ack, 1'b1, "switch_ack within 3 cycles of req");
        repeat (hold) begin
            @(negedge clk);
            compare(switch_ack, 1'b1, "switch_ack while req held");
        end
        @(posedge clk);
        switch_req <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (switch_ack && n < 3);
        compare(switch_ack, 1'b0, "switch_ack low within 3 cycles of req release");
    endtask

    task automatic load_filter_words(input int n);
        bm_pkg::fm_word_t w;
        bit               sent;
        filter_words.delete();
        @(posedge clk);
        q_load_filter <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        compare(filter_ready, 1'b0, "filter_ready on load start");
        while (filter_words.size() < n) begin
            send_word(sent, w);
            if (sent)
                filter_words.push_back(w);
        end
        @(posedge clk);
        read_data_vld <= 1'b0;
    endtask

    task automatic wait_filter_ready();
        int n;
        n = 0;
        while (!filter_ready && n < 8) begin
            @(negedge clk);
            n++;
        end
        compare(filter_ready, 1'b1, "filter_ready after last kernel");
    endtask

    // bank j, byte k at address a = lane j of word 9a+k
    task automatic check_filter_banks(input int kernels);
        bm_pkg::filter_word_t got [`BM_FILTER_LANES];
        bm_pkg::filter_word_t exp;
        for (int a = 0; a < kernels; a++) begin
            @(posedge clk);
            fb_req  <= 1'b1;
            fb_addr <= bm_pkg::filter_addr_t'(a);
            @(posedge clk);
            fb_req <= 1'b0;
            @(negedge clk);
            got[0] = fb_data0;
            got[1] = fb_data1;
            got[2] = fb_data2;
            got[3] = fb_data3;
            for (int j = 0; j < `BM_FILTER_LANES; j++) begin
                for (int k = 0; k < `BM_KERNEL_BYTES; k++)
                    exp[8*k +: 8] = filter_words[`BM_KERNEL_BYTES * a + k][8*j +: 8];
                compare(got[j], exp, $sformatf("bank %0d kernel %0d", j, a));
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------------------
    task automatic axi_load_readback();
        load_ifm_words(IFM_WORDS);
        check_tap_data(ifm_words, "ifm load");
    endtask

    task automatic ofm_write_and_swap();
        bm_pkg::fm_word_t w;
        int               last;
        last = OFM_WORDS - 1;
        for (int a = 0; a < OFM_WORDS; a++) begin
            @(posedge clk);
            w = $urandom;
            ofm_wr_en <= 1'b1;
            ofm_addr  <= bm_pkg::fm_addr_t'(a);
            ofm_data  <= w;
            ofm_words.push_back(w);
            @(negedge clk);
            compare(ofm_done, a == last, $sformatf("ofm_done at address %0d", a));
        end
        @(posedge clk);
        ofm_wr_en <= 1'b0;
        layer_switch(2);                 // OFM side becomes IFM side
        check_tap_data(ofm_words, "ofm after switch");
        layer_switch(2);
        check_tap_data(ifm_words, "ifm after second switch");
    endtask

    task automatic switch_timing();
        bm_pkg::fm_word_t got;
        layer_switch(6);
        layer_switch(1);
        read_tap('0, got);
        compare(got, ifm_words[0], "tap word 0 after two switches");
    endtask

    task automatic filter_packing();
        load_filter_words(FILTER_WORDS);
        wait_filter_ready();
        check_filter_banks(KERNELS);
        @(posedge clk);
        q_load_filter <= 1'b0;
    endtask

    task automatic filter_reload();
        // cut a load short mid-kernel so the restart has state to clear
        load_filter_words(PARTIAL_WORDS);
        @(posedge clk);
        q_load_filter <= 1'b0;
        load_filter_words(FILTER_WORDS);  // also checks the flag drop
        wait_filter_ready();
        check_filter_banks(KERNELS);
        @(posedge clk);
        q_load_filter <= 1'b0;
    endtask

    initial begin
        void'($urandom(32'h449320f7));
        rstn          <= 1'b0;
        q_width       <= `BM_W_SIZE'(SHAPE_W);
        q_height      <= `BM_W_SIZE'(SHAPE_H);
        q_channel     <= `BM_W_CHANNEL'(FILTER_CH);
        q_channel_out <= `BM_W_CHANNEL'(SHAPE_C_OUT);
        q_load_ifm    <= 1'b0;
        q_load_filter <= 1'b0;
        switch_req    <= 1'b0;
        read_data     <= '0;
        read_data_vld <= 1'b0;
        tap_read_en   <= 1'b0;
        tap_read_addr <= '0;
        ofm_wr_en     <= 1'b0;
        ofm_addr      <= '0;
        ofm_data      <= '0;
        fb_req        <= 1'b0;
        fb_addr       <= '0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);

        axi_load_readback();
        ofm_write_and_swap();
        switch_timing();
        filter_packing();
        filter_reload();

        $display("checks %0d, errors %0d, property failures %0d", checks, errors,
                 i_dut.i_props.failures);
        if (errors == 0 && i_dut.i_props.failures == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule
